// ==== rtl/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// instruction memory word address width, giving 256 words.
`define IMEM_ADDR_BITS 8

// data memory word address width, giving 256 words.
`define DMEM_ADDR_BITS 8

// width of a register and of a data memory word.
`define DATA_BITS 32

// word address of the first instruction after reset.
`define RESET_PC 0

`endif

// ==== rtl/cpuPkg.sv ====
package cpuPkg;

	// opcodes not listed here execute as a no-op.
	typedef enum logic [5:0] {
		ADD = 6'd0,
		SUB = 6'd1,
		AND = 6'd2,
		OR = 6'd3,
		ADDI = 6'd4,
		LW = 6'd5,
		SW = 6'd6,
		BEQ = 6'd7,
		HALT = 6'd63
	} opcodeT;

	typedef struct packed {
		logic [4:0] rt;
		logic [10:0] spare;
	} regFieldT;

	// the low half of the word is read either as the signed immediate or as rt.
	typedef union packed {
		logic [15:0] imm;
		regFieldT f;
	} lowFieldT;

	typedef struct packed {
		opcodeT op;
		logic [4:0] rd;
		logic [4:0] rs;
		lowFieldT lo;
	} instrT;

	typedef enum logic [1:0] {
		FETCH,
		EXECUTE,
		MEMORY,
		HALTED
	} coreStateT;

endpackage

// ==== rtl/wishboneBus.sv ====
`include "cpu_config.svh"

interface wishboneBus;
	logic cyc;
	logic stb;
	logic we;
	logic [`DMEM_ADDR_BITS-1:0] adr;
	logic [`DATA_BITS-1:0] datW;
	logic [`DATA_BITS-1:0] datR;
	logic ack;

	modport master (
		output cyc,
		output stb,
		output we,
		output adr,
		output datW,
		input datR,
		input ack
	);

	modport slave (
		input cyc,
		input stb,
		input we,
		input adr,
		input datW,
		output datR,
		output ack
	);
endinterface

// ==== rtl/regFile.sv ====
`include "cpu_config.svh"

module regFile (
	input logic clk,
	input logic [4:0] rsAddr,
	input logic [4:0] rtAddr,
	output logic [`DATA_BITS-1:0] rsData,
	output logic [`DATA_BITS-1:0] rtData,
	input logic we,
	input logic [4:0] wAddr,
	input logic [`DATA_BITS-1:0] wData,
	input logic [4:0] dbgAddr,
	output logic [`DATA_BITS-1:0] dbgData
);
	// register 0 has no storage at all.
	logic [`DATA_BITS-1:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (we && wAddr != 5'd0) begin
			regs[wAddr] <= wData;
		end
	end

	// reads are combinational, so a value written this cycle shows up next cycle.
	assign rsData = (rsAddr == 5'd0) ? '0 : regs[rsAddr];
	assign rtData = (rtAddr == 5'd0) ? '0 : regs[rtAddr];
	assign dbgData = (dbgAddr == 5'd0) ? '0 : regs[dbgAddr];

endmodule

// ==== rtl/cpuCore.sv ====
`include "cpu_config.svh"

module cpuCore (
	input logic clk,
	input logic reset,
	input cpuPkg::instrT instr,
	output logic [`IMEM_ADDR_BITS-1:0] fetchAddr,
	output logic [4:0] rsAddr,
	output logic [4:0] rtAddr,
	input logic [`DATA_BITS-1:0] rsData,
	input logic [`DATA_BITS-1:0] rtData,
	output logic regWe,
	output logic [4:0] regWAddr,
	output logic [`DATA_BITS-1:0] regWData,
	wishboneBus.master bus,
	output logic halted,
	output logic [`IMEM_ADDR_BITS-1:0] pc
);
	cpuPkg::coreStateT state;
	logic [`DATA_BITS-1:0] immExt;
	logic [`DATA_BITS-1:0] aluResult;
	logic isAlu;
	logic isMem;
	logic branchTaken;
	logic [`IMEM_ADDR_BITS-1:0] pcPlusOne;
	logic [`IMEM_ADDR_BITS-1:0] pcNext;

	// pc only moves when an instruction retires, so the instruction memory keeps
	// returning the current word through EXECUTE and MEMORY.
	assign fetchAddr = pc;
	assign halted = (state == cpuPkg::HALTED);

	assign immExt = {{(`DATA_BITS - 16){instr.lo.imm[15]}}, instr.lo.imm};

	assign isAlu = instr.op inside {cpuPkg::ADD, cpuPkg::SUB, cpuPkg::AND, cpuPkg::OR,
		cpuPkg::ADDI};
	assign isMem = instr.op inside {cpuPkg::LW, cpuPkg::SW};

	// SW stores the register named by rd.
	assign rsAddr = instr.rs;
	assign rtAddr = (instr.op == cpuPkg::SW) ? instr.rd : instr.lo.f.rt;

	// the default arm also forms the effective address for LW and SW.
	always_comb begin
		case (instr.op)
			cpuPkg::ADD: aluResult = rsData + rtData;
			cpuPkg::SUB: aluResult = rsData - rtData;
			cpuPkg::AND: aluResult = rsData & rtData;
			cpuPkg::OR: aluResult = rsData | rtData;
			default: aluResult = rsData + immExt;
		endcase
	end

	assign branchTaken = (instr.op == cpuPkg::BEQ) && (rsData == rtData);
	assign pcPlusOne = pc + `IMEM_ADDR_BITS'(1);
	assign pcNext = branchTaken ? pcPlusOne + immExt[`IMEM_ADDR_BITS-1:0] : pcPlusOne;

	// the request goes out while the load or store is still in EXECUTE.
	// The slave then answers in the first MEMORY cycle.
	assign bus.cyc = isMem && (state == cpuPkg::EXECUTE || state == cpuPkg::MEMORY);
	assign bus.stb = bus.cyc;
	assign bus.we = (instr.op == cpuPkg::SW);
	assign bus.adr = aluResult[`DMEM_ADDR_BITS-1:0];
	assign bus.datW = rtData;

	assign regWAddr = instr.rd;
	assign regWData = (state == cpuPkg::MEMORY) ? bus.datR : aluResult;
	assign regWe = (state == cpuPkg::EXECUTE && isAlu) ||
		(state == cpuPkg::MEMORY && bus.ack && instr.op == cpuPkg::LW);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cpuPkg::FETCH;
			pc <= `IMEM_ADDR_BITS'(`RESET_PC);
		end else begin
			case (state)
				cpuPkg::FETCH: begin
					state <= cpuPkg::EXECUTE;
				end
				cpuPkg::EXECUTE: begin
					if (instr.op == cpuPkg::HALT) begin
						state <= cpuPkg::HALTED;
					end else if (isMem) begin
						state <= cpuPkg::MEMORY;
					end else begin
						state <= cpuPkg::FETCH;
						pc <= pcNext;
					end
				end
				cpuPkg::MEMORY: begin
					// wait here for as long as the slave holds off ack.
					if (bus.ack) begin
						state <= cpuPkg::FETCH;
						pc <= pcPlusOne;
					end
				end
				default: begin
					state <= cpuPkg::HALTED;
				end
			endcase
		end
	end

endmodule

// ==== rtl/dataMemory.sv ====
`include "cpu_config.svh"

module dataMemory (
	input logic clk,
	input logic reset,
	wishboneBus.slave bus
);
	logic [`DATA_BITS-1:0] mem [0:(1 << `DMEM_ADDR_BITS)-1];
	logic request;

	// a cycle that was just acknowledged is not taken as a new request.
	assign request = bus.cyc && bus.stb && !bus.ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			bus.ack <= 1'b0;
		end else begin
			bus.ack <= request;
		end
	end

	// read data is captured with the request so it is valid alongside ack.
	always_ff @(posedge clk) begin
		if (request) begin
			bus.datR <= mem[bus.adr];
		end
	end

	// the master holds adr and datW until ack, so the write lands in that cycle.
	always_ff @(posedge clk) begin
		if (bus.ack && bus.we) begin
			mem[bus.adr] <= bus.datW;
		end
	end

endmodule

// ==== rtl/instrMemory.sv ====
`include "cpu_config.svh"

module instrMemory (
	input logic clk,
	input logic [`IMEM_ADDR_BITS-1:0] rdAddr,
	output logic [31:0] rdData,
	input logic wrEn,
	input logic [`IMEM_ADDR_BITS-1:0] wrAddr,
	input logic [31:0] wrData
);
	logic [31:0] mem [0:(1 << `IMEM_ADDR_BITS)-1];

	// the loader port is only used while the core is held in reset.
	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wrAddr] <= wrData;
		end
	end

	always_ff @(posedge clk) begin
		rdData <= mem[rdAddr];
	end

endmodule

// ==== rtl/cpuTop.sv ====
`include "cpu_config.svh"

module cpuTop (
	input logic clk,
	input logic reset,
	input logic progWrite,
	input logic [`IMEM_ADDR_BITS-1:0] progAddr,
	input logic [31:0] progData,
	output logic halted,
	output logic [`IMEM_ADDR_BITS-1:0] pc,
	input logic [4:0] dbgAddr,
	output logic [`DATA_BITS-1:0] dbgData
);
	cpuPkg::instrT instrWord;
	logic [`IMEM_ADDR_BITS-1:0] fetchAddr;
	logic [4:0] rsAddr;
	logic [4:0] rtAddr;
	logic [`DATA_BITS-1:0] rsData;
	logic [`DATA_BITS-1:0] rtData;
	logic regWe;
	logic [4:0] regWAddr;
	logic [`DATA_BITS-1:0] regWData;

	wishboneBus dataBus ();

	cpuCore core (
		.clk(clk),
		.reset(reset),
		.instr(instrWord),
		.fetchAddr(fetchAddr),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.rsData(rsData),
		.rtData(rtData),
		.regWe(regWe),
		.regWAddr(regWAddr),
		.regWData(regWData),
		.bus(dataBus.master),
		.halted(halted),
		.pc(pc)
	);

	regFile regs (
		.clk(clk),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.rsData(rsData),
		.rtData(rtData),
		.we(regWe),
		.wAddr(regWAddr),
		.wData(regWData),
		.dbgAddr(dbgAddr),
		.dbgData(dbgData)
	);

	instrMemory iMem (
		.clk(clk),
		.rdAddr(fetchAddr),
		.rdData(instrWord),
		.wrEn(progWrite),
		.wrAddr(progAddr),
		.wrData(progData)
	);

	dataMemory dMem (
		.clk(clk),
		.reset(reset),
		.bus(dataBus.slave)
	);

endmodule

// ==== sim/cpuTb.sv ====
`include "cpu_config.svh"

module cpuTb;
	// six programs of at most about 150 instructions at three cycles each.
	localparam int TIMEOUT_CYCLES = 4000;

	logic clk;
	logic reset = 1'b1;
	logic progWrite = 1'b0;
	logic [`IMEM_ADDR_BITS-1:0] progAddr = '0;
	logic [31:0] progData = '0;
	logic halted;
	logic [`IMEM_ADDR_BITS-1:0] pc;
	logic [4:0] dbgAddr = '0;
	logic [`DATA_BITS-1:0] dbgData;

	logic [31:0] lfsr = 32'h0e542369;
	logic [31:0] prog [$];
	logic [`DATA_BITS-1:0] modelRegs [0:31];
	logic [`DATA_BITS-1:0] modelMem [0:(1 << `DMEM_ADDR_BITS)-1];
	logic [`IMEM_ADDR_BITS-1:0] haltPc;
	logic [`IMEM_ADDR_BITS-1:0] expectPc;
	logic [`DATA_BITS-1:0] expectReg;
	logic expectHalted = 1'b0;
	logic readCheck = 1'b0;
	logic pcCheck = 1'b0;
	int errorCount = 0;
	int readCount = 0;
	int programCount = 0;
	int cycleCount = 0;

	cpuTop dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Galois form, stepped once for every bit handed out.
	function automatic logic [31:0] randomBits(int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
		end
		return value;
	endfunction

	task automatic emit(cpuPkg::opcodeT op, logic [4:0] rd, logic [4:0] rs, logic [15:0] imm);
		prog.push_back({op, rd, rs, imm});
	endtask

	// rt sits in the top five bits of the low half, a branch offset below it.
	function automatic logic [15:0] rtField(logic [4:0] rt, int offset);
		return {rt, 11'(offset)};
	endfunction

	task automatic runModel();
		logic [`IMEM_ADDR_BITS-1:0] mpc;
		logic [31:0] w;
		logic [`DATA_BITS-1:0] a;
		logic [`DATA_BITS-1:0] b;
		logic [`DATA_BITS-1:0] immExt;
		logic [`DATA_BITS-1:0] addr;
		int steps;
		mpc = `IMEM_ADDR_BITS'(`RESET_PC);
		steps = 0;
		while (steps < 1000 && prog[mpc][31:26] != cpuPkg::HALT) begin
			w = prog[mpc];
			a = modelRegs[w[20:16]];
			b = modelRegs[w[15:11]];
			immExt = {{(`DATA_BITS - 16){w[15]}}, w[15:0]};
			addr = a + immExt;
			case (w[31:26])
				cpuPkg::ADD: modelRegs[w[25:21]] = a + b;
				cpuPkg::SUB: modelRegs[w[25:21]] = a - b;
				cpuPkg::AND: modelRegs[w[25:21]] = a & b;
				cpuPkg::OR: modelRegs[w[25:21]] = a | b;
				cpuPkg::ADDI: modelRegs[w[25:21]] = addr;
				cpuPkg::LW: modelRegs[w[25:21]] = modelMem[addr[`DMEM_ADDR_BITS-1:0]];
				cpuPkg::SW: modelMem[addr[`DMEM_ADDR_BITS-1:0]] = modelRegs[w[25:21]];
				default: ;
			endcase
			modelRegs[0] = '0;
			if (w[31:26] == cpuPkg::BEQ && a == b) begin
				mpc = mpc + `IMEM_ADDR_BITS'(1) + immExt[`IMEM_ADDR_BITS-1:0];
			end else begin
				mpc = mpc + `IMEM_ADDR_BITS'(1);
			end
			steps++;
		end
		haltPc = mpc;
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	// reset stays high for three cycles after the last word is written.
	task automatic loadProgram();
		reset = 1'b1;
		progWrite = 1'b0;
		nextCycle();
		expectPc = `IMEM_ADDR_BITS'(`RESET_PC);
		expectHalted = 1'b0;
		pcCheck = 1'b1;
		foreach (prog[i]) begin
			progWrite = 1'b1;
			progAddr = `IMEM_ADDR_BITS'(i);
			progData = prog[i];
			nextCycle();
		end
		progWrite = 1'b0;
		repeat (3) nextCycle();
		pcCheck = 1'b0;
		reset = 1'b0;
	endtask

	task automatic runProgram(int interruptAfter);
		loadProgram();
		if (interruptAfter > 0) begin
			repeat (interruptAfter) nextCycle();
			loadProgram();
		end
		runModel();
		programCount++;
		while (!halted) nextCycle();
		expectPc = haltPc;
		expectHalted = 1'b1;
		pcCheck = 1'b1;
		repeat (20) nextCycle();
		pcCheck = 1'b0;
		readCheck = 1'b1;
		for (int i = 0; i < 32; i++) begin
			dbgAddr = 5'(i);
			expectReg = modelRegs[i];
			readCount++;
			nextCycle();
		end
		readCheck = 1'b0;
	endtask

	task automatic buildLoop();
		prog.delete();
		emit(cpuPkg::ADDI, 5'd1, 5'd0, 16'(3 + randomBits(4)));
		emit(cpuPkg::ADDI, 5'd2, 5'd0, 16'd0);
		emit(cpuPkg::ADDI, 5'd3, 5'd0, 16'd0);
		emit(cpuPkg::BEQ, 5'd0, 5'd3, rtField(5'd1, 3));
		emit(cpuPkg::ADDI, 5'd3, 5'd3, 16'd1);
		emit(cpuPkg::ADD, 5'd2, 5'd2, rtField(5'd3, 0));
		emit(cpuPkg::BEQ, 5'd0, 5'd0, rtField(5'd0, -4));
		// the sum never equals N here, so this branch falls through.
		emit(cpuPkg::BEQ, 5'd0, 5'd1, rtField(5'd2, 1));
		emit(cpuPkg::ADDI, 5'd4, 5'd0, 16'(randomBits(16)));
		emit(cpuPkg::HALT, 5'd0, 5'd0, 16'd0);
	endtask

	regReadout: assert property (@(negedge clk) !readCheck || dbgData == expectReg)
		else begin
			errorCount++;
			$display("FAILED at %0t: dbgData = %h, expected %h (register %0d)",
				$time, dbgData, expectReg, dbgAddr);
		end
	pcValue: assert property (@(negedge clk) !pcCheck || pc == expectPc)
		else begin
			errorCount++;
			$display("FAILED at %0t: pc = %0d, expected %0d", $time, pc, expectPc);
		end
	haltedValue: assert property (@(negedge clk) !pcCheck || halted == expectHalted)
		else begin
			errorCount++;
			$display("FAILED at %0t: halted = %b, expected %b", $time, halted, expectHalted);
		end

	initial begin
		while (cycleCount < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: the processor did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("%0d programs, %0d registers read, %0d errors", programCount, readCount,
			errorCount);
		$display("Test failures found");
		$finish;
	end

	initial begin
		cpuPkg::opcodeT op;
		logic [7:0] base;
		foreach (modelRegs[i]) modelRegs[i] = '0;

		// every register gets a value first, then random register and immediate ops.
		for (int r = 1; r < 32; r++) begin
			emit(cpuPkg::ADDI, 5'(r), 5'd0, 16'(randomBits(16)));
		end
		repeat (24) begin
			op = cpuPkg::opcodeT'(6'(randomBits(3) % 5));
			emit(op, 5'(randomBits(5)), 5'(randomBits(5)),
				(op == cpuPkg::ADDI) ? 16'(randomBits(16)) : rtField(5'(randomBits(5)), 0));
		end
		emit(cpuPkg::HALT, 5'd0, 5'd0, 16'd0);
		runProgram(0);

		prog.delete();
		emit(cpuPkg::ADDI, 5'd0, 5'd0, 16'h1234);
		emit(cpuPkg::ADD, 5'd0, 5'd1, rtField(5'd2, 0));
		emit(cpuPkg::ADDI, 5'd5, 5'd0, 16'h0055);
		emit(cpuPkg::ADD, 5'd6, 5'd0, rtField(5'd7, 0));
		emit(cpuPkg::SUB, 5'd8, 5'd0, rtField(5'd9, 0));
		emit(cpuPkg::OR, 5'd10, 5'd0, rtField(5'd0, 0));
		emit(cpuPkg::HALT, 5'd0, 5'd0, 16'd0);
		runProgram(0);

		prog.delete();
		base = 8'(randomBits(8));
		emit(cpuPkg::ADDI, 5'd14, 5'd0, {8'd0, base});
		for (int r = 10; r < 14; r++) begin
			emit(cpuPkg::ADDI, 5'(r), 5'd0, 16'(randomBits(16)));
		end
		emit(cpuPkg::ADD, 5'd15, 5'd10, rtField(5'd11, 0));
		emit(cpuPkg::SW, 5'd10, 5'd14, 16'd0);
		emit(cpuPkg::SW, 5'd11, 5'd14, 16'd37);
		emit(cpuPkg::SW, 5'd15, 5'd14, 16'd101);
		emit(cpuPkg::SW, 5'd13, 5'd14, 16'd0);
		emit(cpuPkg::LW, 5'd20, 5'd14, 16'd0);
		emit(cpuPkg::LW, 5'd21, 5'd14, 16'd37);
		// a negative offset from register 0 wraps onto the same word as base plus 101.
		emit(cpuPkg::LW, 5'd22, 5'd0, 16'(int'(base) + 101 - 256));
		emit(cpuPkg::LW, 5'd23, 5'd14, 16'd37);
		emit(cpuPkg::HALT, 5'd0, 5'd0, 16'd0);
		runProgram(0);

		buildLoop();
		runProgram(0);

		// the words after the first HALT must never execute.
		prog.delete();
		emit(cpuPkg::ADDI, 5'd25, 5'd0, 16'(randomBits(16)));
		emit(cpuPkg::ADD, 5'd26, 5'd25, rtField(5'd25, 0));
		emit(cpuPkg::HALT, 5'd0, 5'd0, 16'd0);
		emit(cpuPkg::ADDI, 5'd25, 5'd0, 16'h7777);
		emit(cpuPkg::ADDI, 5'd27, 5'd0, 16'd1);
		emit(cpuPkg::HALT, 5'd0, 5'd0, 16'd0);
		runProgram(0);

		buildLoop();
		runProgram(15);

		$display("%0d programs, %0d registers read, %0d errors", programCount, readCount,
			errorCount);
		if (errorCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/cpuPkg.sv
rtl/wishboneBus.sv
rtl/regFile.sv
rtl/cpuCore.sv
rtl/dataMemory.sv
rtl/instrMemory.sv
rtl/cpuTop.sv
sim/cpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module cpuTb -o cpuTbSim -f project.f; then
	echo "verilator build failed"
	exit 1
fi

output="$(./obj_dir/cpuTbSim)"
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qxF "All tests passed!" <<< "$output"; then
	exit 0
fi
exit 1
